// File: common/cpuPkg.sv
package cpuPkg;

    // ------------------------------------------------------------
    // Data path types
    // ------------------------------------------------------------
    typedef logic [15:0] word_t;    // Data word or address
    typedef logic [7:0]  byte_t;    // One bus byte
    typedef logic [2:0]  regSel_t;  // AX..DI or AL..BH
    typedef logic [11:0] flags_t;   // OF DF IF TF SF ZF - AF - PF 1 CF

    // Operation field of the ALU opcodes, in opcode order
    typedef enum logic [2:0] {
        aluAdd,
        aluOr,
        aluAdc,
        aluSbb,
        aluAnd,
        aluSub,
        aluXor,
        aluCmp
    } aluOp_t;

    // Main sequencer, one-hot
    typedef enum logic [3:0] {
        stFetch    = 4'b0001,
        stModrm    = 4'b0010,
        stExec     = 4'b0100,
        stMemWrite = 4'b1000
    } cpuState_t;

    typedef enum logic [2:0] {
        readByte,       // ModRM byte itself
        readOperand,    // Reg operand, first memory or disp byte
        readSecondReg,  // rm register for mod 11
        readDispHigh,   // Upper disp16 or direct address byte
        readMemLow,
        readMemHigh
    } modrmStage_t;

    // ------------------------------------------------------------
    // Opcode and ModRM field positions
    // ------------------------------------------------------------
    localparam int opW     = 0;  // Word width
    localparam int opD     = 1;  // Direction, reg is destination
    localparam int opImm   = 2;  // Accumulator-immediate family
    localparam int opAluLo = 3;
    localparam int opAluHi = 5;

    localparam int rmLo  = 0;
    localparam int rmHi  = 2;
    localparam int regLo = 3;
    localparam int regHi = 5;
    localparam int modLo = 6;
    localparam int modHi = 7;

    localparam logic [1:0] modNoDisp = 2'b00;
    localparam logic [1:0] modDisp8  = 2'b01;
    localparam logic [1:0] modDisp16 = 2'b10;
    localparam logic [1:0] modReg    = 2'b11;
    localparam logic [2:0] rmDirect  = 3'b110;  // Direct address when mod 00

    // Flag bit positions
    localparam int flagCf = 0;
    localparam int flagPf = 2;
    localparam int flagAf = 4;
    localparam int flagZf = 6;
    localparam int flagSf = 7;
    localparam int flagTf = 8;
    localparam int flagIf = 9;
    localparam int flagDf = 10;
    localparam int flagOf = 11;

    // Reset values
    localparam word_t  resetIp    = 16'hFFF0;
    localparam word_t  resetAx    = 16'h0605;
    localparam word_t  resetCx    = 16'h1245;
    localparam word_t  resetDx    = 16'h64EA;
    localparam word_t  resetBx    = 16'hE004;
    localparam word_t  resetSp    = 16'h0000;
    localparam word_t  resetBp    = 16'h0000;
    localparam word_t  resetSi    = 16'h1234;
    localparam word_t  resetDi    = 16'h0000;
    localparam flags_t flagsReset = 12'h002;  // Only the fixed bit 1

endpackage

// File: hw/regFile.sv
module regFile (
    input  logic            clk25,
    input  logic            rstN,
    input  cpuPkg::regSel_t rdSel,
    input  logic            rdWide,
    output cpuPkg::word_t   rdData,  // Bytes zero-extended
    input  logic            wrEn,
    input  cpuPkg::regSel_t wrSel,
    input  logic            wrWide,
    input  cpuPkg::word_t   wrData,
    input  logic [2:0]      eaRm,
    output cpuPkg::word_t   eaBase
);
    import cpuPkg::*;

    word_t   regs [8];  // AX CX DX BX SP BP SI DI
    regSel_t rdLow;     // Word holding the selected byte
    regSel_t wrLow;

    assign rdLow = {1'b0, rdSel[1:0]};
    assign wrLow = {1'b0, wrSel[1:0]};

    always_comb begin
        if (rdWide)
            rdData = regs[rdSel];
        else if (rdSel[2])
            rdData = {8'h00, regs[rdLow][15:8]};  // AH CH DH BH
        else
            rdData = {8'h00, regs[rdLow][7:0]};
    end

    always_ff @(posedge clk25) begin
        if (!rstN) begin
            regs[0] <= resetAx;
            regs[1] <= resetCx;
            regs[2] <= resetDx;
            regs[3] <= resetBx;
            regs[4] <= resetSp;
            regs[5] <= resetBp;
            regs[6] <= resetSi;
            regs[7] <= resetDi;
        end else if (wrEn) begin
            if (wrWide)
                regs[wrSel] <= wrData;
            else if (wrSel[2])
                regs[wrLow][15:8] <= wrData[7:0];  // Other half untouched
            else
                regs[wrLow][7:0] <= wrData[7:0];
        end
    end

    // ModRM base, mod 00 direct form is handled by the control
    always_comb begin
        case (eaRm)
            3'd0:    eaBase = regs[3] + regs[6];  // BX+SI
            3'd1:    eaBase = regs[3] + regs[7];  // BX+DI
            3'd2:    eaBase = regs[5] + regs[6];  // BP+SI
            3'd3:    eaBase = regs[5] + regs[7];  // BP+DI
            3'd4:    eaBase = regs[6];            // SI
            3'd5:    eaBase = regs[7];            // DI
            3'd6:    eaBase = regs[5];            // BP
            default: eaBase = regs[3];            // BX
        endcase
    end

    // Control never commits an unresolved result
    wrDataKnown: assert property (@(posedge clk25) disable iff (!rstN)
        wrEn |-> !$isunknown(wrData));

endmodule

// File: alu/alu.sv
module alu (
    input  logic           clk25,
    input  logic           rstN,
    input  cpuPkg::word_t  op1,  // Destination
    input  cpuPkg::word_t  op2,  // Source
    input  cpuPkg::aluOp_t aluOp,
    input  logic           aluWide,
    input  logic           flagsLoad,
    output cpuPkg::word_t  result
);
    import cpuPkg::*;

    flags_t      flags;
    flags_t      nextFlags;
    logic [16:0] sum;      // Bit 16 is the word carry
    logic        carryIn;  // CF for ADC and SBB only
    logic        addType;
    logic        subType;
    logic        signA;
    logic        signB;
    logic        signR;
    logic        carryOut;

    assign addType = (aluOp == aluAdd) || (aluOp == aluAdc);
    assign subType = (aluOp == aluSub) || (aluOp == aluSbb) || (aluOp == aluCmp);
    assign carryIn = ((aluOp == aluAdc) || (aluOp == aluSbb)) && flags[flagCf];

    // ------------------------------------------------------------
    // Result
    // ------------------------------------------------------------
    always_comb begin
        case (aluOp)
            aluAdd, aluAdc:         sum = {1'b0, op1} + {1'b0, op2} + 17'(carryIn);
            aluSbb, aluSub, aluCmp: sum = {1'b0, op1} - {1'b0, op2} - 17'(carryIn);
            aluOr:                  sum = {1'b0, op1 | op2};
            aluAnd:                 sum = {1'b0, op1 & op2};
            default:                sum = {1'b0, op1 ^ op2};  // XOR
        endcase
    end

    assign result = sum[15:0];

    // Byte operands arrive zero-extended, so bit 8 is the byte carry
    assign signA    = aluWide ? op1[15] : op1[7];
    assign signB    = aluWide ? op2[15] : op2[7];
    assign signR    = aluWide ? sum[15] : sum[7];
    assign carryOut = aluWide ? sum[16] : sum[8];

    // ------------------------------------------------------------
    // Flags
    // ------------------------------------------------------------
    always_comb begin
        nextFlags = flagsReset;  // Fixed bits, logical ops clear OF CF AF
        nextFlags[flagDf] = flags[flagDf];
        nextFlags[flagIf] = flags[flagIf];
        nextFlags[flagTf] = flags[flagTf];
        nextFlags[flagSf] = signR;
        nextFlags[flagZf] = aluWide ? (sum[15:0] == 16'h0000) : (sum[7:0] == 8'h00);
        nextFlags[flagPf] = ~^sum[7:0];  // Even parity of low byte
        if (addType || subType) begin
            nextFlags[flagCf] = carryOut;
            // Nibble carry or borrow, carry-in included
            nextFlags[flagAf] = op1[4] ^ op2[4] ^ sum[4];
            if (addType)
                nextFlags[flagOf] = (signA == signB) && (signR != signA);
            else
                nextFlags[flagOf] = (signA != signB) && (signR != signA);
        end
    end

    always_ff @(posedge clk25) begin
        if (!rstN)
            flags <= flagsReset;
        else if (flagsLoad)
            flags <= nextFlags;
    end

endmodule

// File: control/cpuControl.sv
module cpuControl (
    input  logic            clk25,
    input  logic            rstN,
    input  cpuPkg::byte_t   i,
    output cpuPkg::byte_t   o,
    output logic            w,
    output cpuPkg::word_t   ip,
    output cpuPkg::word_t   ea,
    output logic            useEa,   // Bus points at ea
    output cpuPkg::regSel_t rdSel,
    output logic            rdWide,
    input  cpuPkg::word_t   rdData,
    output logic            wrEn,
    output cpuPkg::regSel_t wrSel,
    output logic            wrWide,
    output cpuPkg::word_t   wrData,
    output logic [2:0]      eaRm,
    input  cpuPkg::word_t   eaBase,
    output cpuPkg::word_t   op1,
    output cpuPkg::word_t   op2,
    output cpuPkg::aluOp_t  aluOp,
    output logic            aluWide,
    output logic            flagsLoad,
    input  cpuPkg::word_t   result
);
    import cpuPkg::*;

    cpuState_t   state;
    modrmStage_t stage;
    byte_t       opcode;
    byte_t       modrm;
    byte_t       dataHigh;  // Upper result byte for memWrite
    logic [1:0]  immStep;   // 0 low imm, 1 high imm, 2 compute
    logic        memHigh;   // Second byte of a word write
    logic [1:0]  modField;
    logic        regDest;   // Result goes to a register
    logic        isCmp;

    assign modField = modrm[modHi:modLo];
    assign regDest  = (modField == modReg) || opcode[opD];
    assign aluOp    = aluOp_t'(opcode[opAluHi:opAluLo]);
    assign isCmp    = (aluOp == aluCmp);
    assign aluWide  = opcode[opW];
    assign rdWide   = opcode[opW];
    assign eaRm     = i[rmHi:rmLo];  // Valid while i holds ModRM
    assign wrData   = result;

    // Register write and flag load in the compute cycle
    always_comb begin
        flagsLoad = 1'b0;
        wrEn      = 1'b0;
        wrSel     = modrm[rmHi:rmLo];
        wrWide    = opcode[opW];
        if (state == stExec) begin
            if (!opcode[opImm]) begin
                flagsLoad = 1'b1;
                wrEn      = !isCmp && regDest;
                if (opcode[opD])
                    wrSel = modrm[regHi:regLo];
            end else if (immStep == 2'd2) begin
                flagsLoad = 1'b1;
                wrEn      = !isCmp;
                wrSel     = '0;  // AL or AX
            end
        end
    end

    // ------------------------------------------------------------
    // Sequencer
    // ------------------------------------------------------------
    always_ff @(posedge clk25) begin
        if (!rstN) begin
            state   <= stFetch;
            stage   <= readByte;
            ip      <= resetIp;
            useEa   <= 1'b0;
            w       <= 1'b0;
            o       <= '0;
            rdSel   <= '0;
            immStep <= 2'd0;
            memHigh <= 1'b0;
        end else begin
            case (state)
                stFetch: begin
                    opcode  <= i;
                    ip      <= ip + 16'd1;
                    stage   <= readByte;
                    immStep <= 2'd0;
                    memHigh <= 1'b0;
                    casez (i)
                        8'b00???0??: state <= stModrm;
                        8'b00???10?: begin
                            rdSel <= '0;  // Accumulator
                            state <= stExec;
                        end
                        default: state <= stFetch;  // One-byte no-op
                    endcase
                end

                stModrm: case (stage)
                    readByte: begin
                        modrm <= i;
                        rdSel <= i[regHi:regLo];
                        ea    <= (i[modHi:modLo] == modNoDisp && i[rmHi:rmLo] == rmDirect)
                                 ? 16'h0000 : eaBase;
                        // Memory straight away for mod 00 without displacement
                        useEa <= (i[modHi:modLo] == modNoDisp) && (i[rmHi:rmLo] != rmDirect);
                        ip    <= ip + 16'd1;
                        stage <= readOperand;
                    end
                    readOperand: begin
                        // d steers reg operand, i fills the other side for now
                        op1   <= opcode[opD] ? rdData : {8'h00, i};
                        op2   <= opcode[opD] ? {8'h00, i} : rdData;
                        rdSel <= modrm[rmHi:rmLo];
                        case (modField)
                            modNoDisp: begin
                                if (modrm[rmHi:rmLo] == rmDirect) begin
                                    ea[7:0] <= i;
                                    ip      <= ip + 16'd1;
                                    stage   <= readDispHigh;
                                end else if (opcode[opW]) begin
                                    ea    <= ea + 16'd1;
                                    stage <= readMemHigh;
                                end else begin
                                    state <= stExec;
                                end
                            end
                            modDisp8: begin
                                ea    <= ea + {{8{i[7]}}, i};  // Sign extended
                                ip    <= ip + 16'd1;
                                useEa <= 1'b1;
                                stage <= readMemLow;
                            end
                            modDisp16: begin
                                ea    <= ea + {8'h00, i};
                                ip    <= ip + 16'd1;
                                stage <= readDispHigh;
                            end
                            default: stage <= readSecondReg;
                        endcase
                    end
                    readSecondReg: begin
                        if (opcode[opD])
                            op2 <= rdData;
                        else
                            op1 <= rdData;
                        state <= stExec;
                    end
                    readDispHigh: begin
                        ea[15:8] <= ea[15:8] + i;
                        ip       <= ip + 16'd1;
                        useEa    <= 1'b1;
                        stage    <= readMemLow;
                    end
                    readMemLow: begin
                        if (opcode[opD])
                            op2 <= {8'h00, i};
                        else
                            op1 <= {8'h00, i};
                        if (opcode[opW]) begin
                            ea    <= ea + 16'd1;
                            stage <= readMemHigh;
                        end else begin
                            state <= stExec;
                        end
                    end
                    default: begin  // readMemHigh
                        if (opcode[opD])
                            op2[15:8] <= i;
                        else
                            op1[15:8] <= i;
                        ea    <= ea - 16'd1;  // Back to the write address
                        state <= stExec;
                    end
                endcase

                stExec: begin
                    if (!opcode[opImm]) begin
                        if (!isCmp && !regDest) begin
                            o        <= result[7:0];
                            dataHigh <= result[15:8];
                            w        <= 1'b1;
                            state    <= stMemWrite;
                        end else begin
                            useEa <= 1'b0;
                            state <= stFetch;
                        end
                    end else begin
                        case (immStep)
                            2'd0: begin
                                op1     <= rdData;
                                op2     <= {8'h00, i};
                                ip      <= ip + 16'd1;
                                immStep <= opcode[opW] ? 2'd1 : 2'd2;
                            end
                            2'd1: begin
                                op2[15:8] <= i;
                                ip        <= ip + 16'd1;
                                immStep   <= 2'd2;
                            end
                            default: state <= stFetch;
                        endcase
                    end
                end

                stMemWrite: begin
                    if (opcode[opW] && !memHigh) begin
                        o       <= dataHigh;
                        ea      <= ea + 16'd1;
                        memHigh <= 1'b1;
                    end else begin
                        w     <= 1'b0;
                        useEa <= 1'b0;
                        state <= stFetch;
                    end
                end

                default: state <= stFetch;
            endcase
        end
    end

    stateOneHot: assert property (@(posedge clk25) disable iff (!rstN)
        $onehot(state));

    // A write strobe never lands on the code address
    writeAtEa: assert property (@(posedge clk25) disable iff (!rstN)
        w |-> useEa);

endmodule

// File: hw/cpuTop.sv
module cpuTop (
    input  logic          clk25,
    input  logic          rstN,
    input  cpuPkg::byte_t i,  // Read byte at a
    output cpuPkg::word_t a,
    output cpuPkg::byte_t o,  // Write byte
    output logic          w   // Write strobe
);
    import cpuPkg::*;

    // Bus addressing
    word_t   ip;
    word_t   ea;
    logic    useEa;

    // Register file
    regSel_t rdSel;
    logic    rdWide;
    word_t   rdData;
    logic    wrEn;
    regSel_t wrSel;
    logic    wrWide;
    word_t   wrData;
    logic [2:0] eaRm;
    word_t   eaBase;

    // ALU
    word_t   op1;
    word_t   op2;
    aluOp_t  aluOp;
    logic    aluWide;
    logic    flagsLoad;
    word_t   result;

    // Code fetch by default, data while an operand is at ea
    assign a = useEa ? ea : ip;

    // ------------------------------------------------------------
    // Blocks, all wires share the port names
    // ------------------------------------------------------------
    cpuControl control (.*);

    regFile regs (.*);

    alu alu (.*);

endmodule

// File: verification/cpuMemModel.sv
module cpuMemModel (
    input  logic          clk25,
    input  cpuPkg::word_t addr,    // Bus address a
    input  cpuPkg::byte_t wrData,  // Bus byte o
    input  logic          wrEn,    // Write strobe w
    output cpuPkg::byte_t rdData   // Back to the core as i
);
    import cpuPkg::*;

    // ------------------------------------------------------------
    // Storage, 64 KiB
    // ------------------------------------------------------------
    // The testbench writes fill and program bytes straight into cells
    byte_t cells [65536];

    // Read data follows the address within the same cycle
    assign rdData = cells[addr];

    // One byte per strobed edge
    always @(posedge clk25) begin
        if (wrEn === 1'b1)
            cells[addr] <= wrData;
    end

endmodule

// File: verification/cpuTb.sv
module cpuTb;
    import cpuPkg::*;

    localparam word_t codeBase   = 16'hFFF0;        // Reset address of the core
    localparam int    codeLen    = 51;
    localparam int    cycleLimit = 12 * codeLen + 20;
    localparam word_t stopAddr   = codeBase + 16'(codeLen - 1);  // Last no-op

    logic  clk25;
    logic  rstN;
    word_t a;
    byte_t i;
    byte_t o;
    logic  w;

    int errors = 0;
    int checks = 0;
    int cycles = 0;

    word_t gotAddr [$];  // Writes seen on the bus
    byte_t gotData [$];
    word_t expAddr [$];  // Expected writes in order
    byte_t expData [$];

    // Program bytes from FFF0 upward through the wrap to 0000
    byte_t code [codeLen] = '{
        8'h00, 8'h00,                // ADD [BX+SI], AL
        8'h29, 8'h49, 8'hF0,         // SUB [BX+DI-10h], CX
        8'h21, 8'h94, 8'h23, 8'h01,  // AND [SI+0123h], DX
        8'h09, 8'hB7, 8'h00, 8'h10,  // OR [BX+1000h], SI
        8'h31, 8'h54, 8'h7F,         // XOR [SI+7Fh], DX
        8'h31, 8'h0E, 8'h21, 8'h43,  // XOR [4321h], CX
        8'h05, 8'h11, 8'h23,         // ADD AX, 2311h
        8'h31, 8'h06, 8'h00, 8'h50,  // XOR [5000h], AX
        8'h3C, 8'h80,                // CMP AL, 80h sets CF
        8'h14, 8'h00,                // ADC AL, 00h
        8'h30, 8'h06, 8'h00, 8'h51,  // XOR [5100h], AL
        8'h1C, 8'h05,                // SBB AL, 05h
        8'h30, 8'h06, 8'h01, 8'h51,  // XOR [5101h], AL
        8'h03, 8'hCA,                // ADD CX, DX
        8'h31, 8'h0E, 8'h00, 8'h52,  // XOR [5200h], CX
        8'h90, 8'h90, 8'h90, 8'h90   // No-op tail
    };

    cpuTop dut (
        .clk25 (clk25),
        .rstN  (rstN),
        .i     (i),
        .a     (a),
        .o     (o),
        .w     (w)
    );

    cpuMemModel mem (
        .clk25  (clk25),
        .addr   (a),
        .wrData (o),
        .wrEn   (w),
        .rdData (i)
    );

    initial begin
        clk25 = 1'b0;
        forever #20 clk25 = ~clk25;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    // Background contents depend on every address bit
    function automatic byte_t fillByte(input word_t addr);
        return addr[7:0] ^ {addr[11:8], addr[15:12]} ^ 8'h5A;
    endfunction

    function automatic word_t fillWord(input word_t addr);
        return {fillByte(addr + 16'd1), fillByte(addr)};  // Little endian
    endfunction

    task automatic checkValue(input string name, input logic [15:0] got,
                              input logic [15:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("error %s: got %h, expected %h", name, got, expected);
        end
    endtask

    task automatic addWrite(input word_t addr, input byte_t data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic addWord(input word_t addr, input word_t data);
        addWrite(addr, data[7:0]);  // Low byte goes out first
        addWrite(addr + 16'd1, data[15:8]);
    endtask

    task automatic loadMemory();
        word_t addr;
        for (int k = 0; k < 65536; k++)
            mem.cells[k] = fillByte(word_t'(k));
        for (int k = 0; k < codeLen; k++) begin
            addr = codeBase + word_t'(k);  // Wraps past FFFF
            mem.cells[addr] = code[k];
        end
    endtask

    // Registers start at AX 0605, CX 1245, DX 64EA, BX E004, SI 1234, DI 0
    task automatic buildTable();
        addWrite(16'hF238, fillByte(16'hF238) + 8'h05);    // BX+SI, AL
        addWord(16'hDFF4, fillWord(16'hDFF4) - 16'h1245);  // Disp8 F0 is -10h
        addWord(16'h1357, fillWord(16'h1357) & 16'h64EA);
        addWord(16'hF004, fillWord(16'hF004) | 16'h1234);
        addWord(16'h12B3, fillWord(16'h12B3) ^ 16'h64EA);
        addWord(16'h4321, fillWord(16'h4321) ^ 16'h1245);  // Direct address
        addWord(16'h5000, fillWord(16'h5000) ^ 16'h2916);  // AX 0605 + 2311
        addWrite(16'h5100, fillByte(16'h5100) ^ 8'h17);    // 16 + 00 + CF
        addWrite(16'h5101, fillByte(16'h5101) ^ 8'h12);    // XOR left CF clear
        addWord(16'h5200, fillWord(16'h5200) ^ 16'h772F);  // CX 1245 + 64EA
    endtask

    task automatic compareWrites();
        for (int k = 0; k < expAddr.size(); k++) begin
            if (k >= gotAddr.size()) begin
                errors++;
                $display("Write %0d to address %h never happened", k, expAddr[k]);
            end else begin
                checkValue($sformatf("a of write %0d", k), gotAddr[k], expAddr[k]);
                checkValue($sformatf("o of write %0d", k), gotData[k], expData[k]);
            end
        end
        checkValue("write count", 16'(gotAddr.size()), 16'(expAddr.size()));
    endtask

    // Memory takes o at a on this same edge
    always @(posedge clk25) begin
        if (rstN === 1'b1 && w === 1'b1) begin
            gotAddr.push_back(a);
            gotData.push_back(o);
        end
    end

    // ------------------------------------------------------------
    // Run
    // ------------------------------------------------------------
    initial begin
        rstN = 1'b0;
        loadMemory();
        buildTable();
        repeat (5) @(posedge clk25);
        rstN <= 1'b1;
        @(negedge clk25);
        checkValue("a", a, codeBase);  // Core sits at the reset address
        checkValue("w", w, 16'h0000);
        // Program is done once the fetch reaches the last no-op
        while (a !== stopAddr && cycles < cycleLimit) begin
            @(negedge clk25);
            cycles++;
        end
        if (cycles >= cycleLimit) begin
            errors++;
            $display("Timeout, the program end was not reached in %0d cycles", cycleLimit);
        end else begin
            compareWrites();
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: all.f
common/cpuPkg.sv
hw/regFile.sv
alu/alu.sv
control/cpuControl.sv
hw/cpuTop.sv
verification/cpuMemModel.sv
verification/cpuTb.sv
